//--- rtl/card_glue_pkg.sv
// shared vector typedefs and audio widening constants for the card glue logic
`default_nettype none

package card_glue_pkg;

    // ==============================
    // bus and video widths
    // ==============================

    // one byte on the apple ii data bus
    typedef logic [7:0] bus_data_t;

    typedef logic [7:0] color_t;      // single colour channel
    typedef logic [9:0] screen_y_t;   // line number from the video timing

    // ==============================
    // audio widths
    // ==============================

    // raw unsigned card audio, as the sprite card and mockingboard give it
    typedef logic [9:0] audio_src_t;

    // mixed sample handed on to the audio path
    typedef logic [15:0] audio_sample_t;

    // 10 bit sources land in a 13 bit space
    localparam int SRC_AUDIO_SHIFT = 3;

    // speaker is a single bit, placed at the top of the 13 bit space
    localparam int SPEAKER_SHIFT = 12;

    // three 13 bit terms summed stay well below 16 bits
    //   8184 + 8184 + 4096 = 20464

endpackage : card_glue_pkg

`default_nettype wire

//--- rtl/por_reset_gen.sv
// power-on reset stretcher with a two-flop synchronized release
`timescale 1ns/1ps
`default_nettype none

module por_reset_gen #(
    parameter int RESET_CYCLES = 100   // clocks held after arst release
) (
    input  wire  clk_logic_w,
    input  wire  arst,
    output logic device_rst_o
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [1:0]       sync_r;    // release synchronizer
    logic [CNT_W-1:0] count_r;   // stretch counter

    // assert at once, release only after the synchronizer and the count
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            sync_r       <= 2'b00;
            count_r      <= '0;
            device_rst_o <= 1'b1;
        end else begin
            sync_r <= {sync_r[0], 1'b1};   // shift in the release
            if (sync_r[1] && device_rst_o) begin
                // counting only once the release is clean
                if (count_r == CNT_W'(RESET_CYCLES - 1)) begin
                    device_rst_o <= 1'b0;   // done, hold low from here on
                end else begin
                    count_r <= count_r + 1'b1;
                end
            end
        end
    end

endmodule : por_reset_gen

`default_nettype wire

//--- rtl/status_leds.sv
// heartbeat divider and phi1/q3 edge-activity counters for the status leds
`timescale 1ns/1ps
`default_nettype none

module status_leds #(
    parameter int HEARTBEAT_CYCLES = 10_000_000,   // clocks per heartbeat toggle
    parameter int ACTIVITY_BITS    = 11            // width of each edge counter
) (
    input  wire        clk_logic_w,
    input  wire        arst,
    input  wire        a2_phi1_i,
    input  wire        a2_q3_i,
    output logic [1:0] led_o,
    output logic [1:0] activity_o
);

    localparam int HB_W = $clog2(HEARTBEAT_CYCLES + 1);

    // ==============================
    // heartbeat
    // ==============================

    logic [HB_W-1:0] hb_cnt_r;
    logic            heartbeat_r;

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            hb_cnt_r    <= '0;
            heartbeat_r <= 1'b0;
        end else if (hb_cnt_r == HB_W'(HEARTBEAT_CYCLES - 1)) begin
            hb_cnt_r    <= '0;
            heartbeat_r <= ~heartbeat_r;   // one toggle per period
        end else begin
            hb_cnt_r <= hb_cnt_r + 1'b1;
        end
    end

    // ==============================
    // bus clock activity
    // ==============================

    logic [1:0] bus_clk_w;   // bit 0 phi1, bit 1 q3
    logic [1:0] meta_r;      // first sync flop
    logic [1:0] sync_r;      // second sync flop
    logic [1:0] prev_r;      // last synced value, edge detect

    assign bus_clk_w = {a2_q3_i, a2_phi1_i};

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            meta_r <= '0;
            sync_r <= '0;
            prev_r <= '0;
        end else begin
            meta_r <= bus_clk_w;   // async apple ii clocks
            sync_r <= meta_r;
            prev_r <= sync_r;
        end
    end

    // one counter per bus clock, same logic for both
    for (genvar i = 0; i < 2; i++) begin : g_activity
        logic [ACTIVITY_BITS-1:0] cnt_r;

        always_ff @(posedge clk_logic_w or posedge arst) begin
            if (arst) begin
                cnt_r <= '0;
            end else if (sync_r[i] && !prev_r[i]) begin
                cnt_r <= cnt_r + 1'b1;   // rising edge seen
            end
        end

        assign activity_o[i] = cnt_r[ACTIVITY_BITS-1];   // msb blinks slow enough to see
    end

    // led 0 active low heartbeat, led 1 shows phi1 activity as on the board
    assign led_o[0] = ~heartbeat_r;
    assign led_o[1] = activity_o[0];

endmodule : status_leds

`default_nettype wire

//--- rtl/bus_data_arbiter.sv
// slot card read-data priority mux, bus direction and irq combine
`timescale 1ns/1ps
`default_nettype none

module bus_data_arbiter
    import card_glue_pkg::*;
#(
    parameter bit IRQ_OUT_ENABLE      = 1'b1,   // let cards pull the bus irq
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1    // let the fpga drive the data bus
) (
    input  wire       ssc_rd_i,      // serial card read enable
    input  wire       ssp_rd_i,      // sprite card read enable
    input  wire       mb_rd_i,       // mockingboard read enable
    input  wire       bus_data_t ssc_data_i,
    input  wire       bus_data_t ssp_data_i,
    input  wire       bus_data_t mb_data_i,
    input  wire       ssc_irq_n_i,
    input  wire       ssp_irq_n_i,
    input  wire       mb_irq_n_i,
    output bus_data_t a2_d_o,
    output logic      a2_d_dir_o,
    output logic      a2_irq_n_o
);

    logic any_rd_w;   // some card is answering a read
    logic irq_n_w;    // wired-and of the card irqs

    // fixed priority, serial card first
    always_comb begin
        if (ssc_rd_i) begin
            a2_d_o = ssc_data_i;
        end else if (ssp_rd_i) begin
            a2_d_o = ssp_data_i;
        end else if (mb_rd_i) begin
            a2_d_o = mb_data_i;
        end else begin
            a2_d_o = '0;   // nobody reading, bus stays an input anyway
        end
    end

    assign any_rd_w = ssc_rd_i | ssp_rd_i | mb_rd_i;

    // 1 = fpga to apple ii
    assign a2_d_dir_o = any_rd_w & BUS_DATA_OUT_ENABLE;

    // any low irq pulls the line low
    assign irq_n_w    = ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i;
    assign a2_irq_n_o = IRQ_OUT_ENABLE ? irq_n_w : 1'b1;

endmodule : bus_data_arbiter

`default_nettype wire

//--- rtl/audio_mixer.sv
// two-stage valid/ready pipeline that widens and sums the card audio sources
`timescale 1ns/1ps
`default_nettype none

module audio_mixer
    import card_glue_pkg::*;
#(
    parameter bit SPEAKER_ENABLE = 1'b0   // speaker on regardless of dip switch
) (
    input  wire           clk_logic_w,
    input  wire           arst,
    input  wire           speaker_i,        // 1-bit apple ii speaker
    input  wire           sw_speaker_n_i,   // dip switch, low = speaker on
    input  wire           audio_src_t ssp_audio_i,
    input  wire           audio_src_t mb_audio_l_i,
    input  wire           audio_src_t mb_audio_r_i,
    input  wire           audio_valid_i,
    output logic          audio_ready_o,
    output audio_sample_t mix_l_o,
    output audio_sample_t mix_r_o,
    output logic          mix_valid_o,
    input  wire           mix_ready_i
);

    localparam int WIDE_W = $bits(audio_src_t) + SRC_AUDIO_SHIFT;   // 13 bits

    logic              spk_on_w;   // speaker bit gated by its enable
    logic [WIDE_W-1:0] spk_w;
    logic              s1_ready_w;
    logic              s2_ready_w;

    // ==============================
    // stage 1 widen and gate
    // ==============================

    logic              s1_valid_r;
    logic [WIDE_W-1:0] s1_ssp_r;
    logic [WIDE_W-1:0] s1_mb_l_r;
    logic [WIDE_W-1:0] s1_mb_r_r;
    logic [WIDE_W-1:0] s1_spk_r;

    assign spk_on_w = speaker_i & (SPEAKER_ENABLE | ~sw_speaker_n_i);
    assign spk_w    = spk_on_w ? (WIDE_W'(1) << SPEAKER_SHIFT) : '0;

    // a stage takes new data when it is empty or its content moves on
    assign s2_ready_w    = ~mix_valid_o | mix_ready_i;
    assign s1_ready_w    = ~s1_valid_r | s2_ready_w;
    assign audio_ready_o = s1_ready_w;   // low only with both stages full

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            s1_valid_r <= 1'b0;
        end else if (s1_ready_w) begin
            s1_valid_r <= audio_valid_i;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (audio_valid_i && s1_ready_w) begin
            s1_ssp_r  <= WIDE_W'(ssp_audio_i) << SRC_AUDIO_SHIFT;
            s1_mb_l_r <= WIDE_W'(mb_audio_l_i) << SRC_AUDIO_SHIFT;
            s1_mb_r_r <= WIDE_W'(mb_audio_r_i) << SRC_AUDIO_SHIFT;
            s1_spk_r  <= spk_w;
        end
    end

    // ==============================
    // stage 2 sums
    // ==============================

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            mix_valid_o <= 1'b0;
        end else if (s2_ready_w) begin
            mix_valid_o <= s1_valid_r;
        end
    end

    // zero extend first, the 16 bit sum has headroom
    always_ff @(posedge clk_logic_w) begin
        if (s1_valid_r && s2_ready_w) begin
            mix_l_o <= audio_sample_t'(s1_ssp_r) + audio_sample_t'(s1_mb_l_r)
                       + audio_sample_t'(s1_spk_r);
            mix_r_o <= audio_sample_t'(s1_ssp_r) + audio_sample_t'(s1_mb_r_r)
                       + audio_sample_t'(s1_spk_r);
        end
    end

endmodule : audio_mixer

`default_nettype wire

//--- rtl/scanline_dimmer.sv
// registered pixel stage that halves the colour on odd screen lines
`timescale 1ns/1ps
`default_nettype none

module scanline_dimmer
    import card_glue_pkg::*;
#(
    parameter bit SCANLINES_ENABLE = 1'b0   // force scanlines on
) (
    input  wire    clk_logic_w,
    input  wire    arst,
    input  wire    sw_scanlines_n_i,   // dip switch, low = scanlines on
    input  wire    screen_y_t screen_y_i,
    input  wire    color_t r_i,
    input  wire    color_t g_i,
    input  wire    color_t b_i,
    output color_t r_o,
    output color_t g_o,
    output color_t b_o
);

    logic dim_w;   // this line gets darkened

    // half brightness, top bit cleared
    function automatic color_t halve(input color_t c);
        return {1'b0, c[$bits(color_t)-1:1]};
    endfunction

    assign dim_w = (SCANLINES_ENABLE | ~sw_scanlines_n_i) & screen_y_i[0];

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            r_o <= '0;
            g_o <= '0;
            b_o <= '0;
        end else begin
            r_o <= dim_w ? halve(r_i) : r_i;
            g_o <= dim_w ? halve(g_i) : g_i;
            b_o <= dim_w ? halve(b_i) : b_i;
        end
    end

endmodule : scanline_dimmer

`default_nettype wire

//--- rtl/card_glue_top.sv
// card glue top level, parameters and instances of reset, status, bus, audio and pixel logic
`timescale 1ns/1ps
`default_nettype none

module card_glue_top
    import card_glue_pkg::*;
#(
    parameter int RESET_CYCLES        = 100,
    parameter int HEARTBEAT_CYCLES    = 10_000_000,   // 0.5 s at the logic clock
    parameter int ACTIVITY_BITS       = 11,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit SCANLINES_ENABLE    = 1'b0,
    parameter bit SPEAKER_ENABLE      = 1'b0
) (
    input  wire           clk_logic_w,
    input  wire           arst,
    // slot cards
    input  wire           ssc_rd_i,
    input  wire           ssp_rd_i,
    input  wire           mb_rd_i,
    input  wire           bus_data_t ssc_data_i,
    input  wire           bus_data_t ssp_data_i,
    input  wire           bus_data_t mb_data_i,
    input  wire           ssc_irq_n_i,
    input  wire           ssp_irq_n_i,
    input  wire           mb_irq_n_i,
    output bus_data_t     a2_d_o,
    output logic          a2_d_dir_o,
    output logic          a2_irq_n_o,
    // audio
    input  wire           speaker_i,
    input  wire           audio_src_t ssp_audio_i,
    input  wire           audio_src_t mb_audio_l_i,
    input  wire           audio_src_t mb_audio_r_i,
    input  wire           audio_valid_i,
    output logic          audio_ready_o,
    output audio_sample_t mix_l_o,
    output audio_sample_t mix_r_o,
    output logic          mix_valid_o,
    input  wire           mix_ready_i,
    // pixels
    input  wire           screen_y_t screen_y_i,
    input  wire           color_t r_i,
    input  wire           color_t g_i,
    input  wire           color_t b_i,
    output color_t        r_o,
    output color_t        g_o,
    output color_t        b_o,
    // board
    input  wire           a2_phi1_i,
    input  wire           a2_q3_i,
    input  wire    [1:0]  dip_switches_n_i,   // 0 scanlines, 1 speaker
    output logic   [1:0]  led_o,
    output logic   [1:0]  activity_o
);

    logic device_rst;   // stretched reset for everything below

    // ==============================
    // reset and status
    // ==============================

    por_reset_gen #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_por_reset_gen (
        .clk_logic_w  (clk_logic_w),
        .arst         (arst),
        .device_rst_o (device_rst)
    );

    status_leds #(
        .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES),
        .ACTIVITY_BITS    (ACTIVITY_BITS)
    ) u_status_leds (
        .clk_logic_w (clk_logic_w),
        .arst        (device_rst),
        .a2_phi1_i   (a2_phi1_i),
        .a2_q3_i     (a2_q3_i),
        .led_o       (led_o),
        .activity_o  (activity_o)
    );

    // ==============================
    // apple ii bus
    // ==============================

    bus_data_arbiter #(
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE),
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE)
    ) u_bus_data_arbiter (
        .ssc_rd_i    (ssc_rd_i),
        .ssp_rd_i    (ssp_rd_i),
        .mb_rd_i     (mb_rd_i),
        .ssc_data_i  (ssc_data_i),
        .ssp_data_i  (ssp_data_i),
        .mb_data_i   (mb_data_i),
        .ssc_irq_n_i (ssc_irq_n_i),
        .ssp_irq_n_i (ssp_irq_n_i),
        .mb_irq_n_i  (mb_irq_n_i),
        .a2_d_o      (a2_d_o),
        .a2_d_dir_o  (a2_d_dir_o),
        .a2_irq_n_o  (a2_irq_n_o)
    );

    // ==============================
    // audio and video
    // ==============================

    audio_mixer #(
        .SPEAKER_ENABLE (SPEAKER_ENABLE)
    ) u_audio_mixer (
        .clk_logic_w    (clk_logic_w),
        .arst           (device_rst),
        .speaker_i      (speaker_i),
        .sw_speaker_n_i (dip_switches_n_i[1]),
        .ssp_audio_i    (ssp_audio_i),
        .mb_audio_l_i   (mb_audio_l_i),
        .mb_audio_r_i   (mb_audio_r_i),
        .audio_valid_i  (audio_valid_i),
        .audio_ready_o  (audio_ready_o),
        .mix_l_o        (mix_l_o),
        .mix_r_o        (mix_r_o),
        .mix_valid_o    (mix_valid_o),
        .mix_ready_i    (mix_ready_i)
    );

    scanline_dimmer #(
        .SCANLINES_ENABLE (SCANLINES_ENABLE)
    ) u_scanline_dimmer (
        .clk_logic_w      (clk_logic_w),
        .arst             (device_rst),
        .sw_scanlines_n_i (dip_switches_n_i[0]),
        .screen_y_i       (screen_y_i),
        .r_i              (r_i),
        .g_i              (g_i),
        .b_i              (b_i),
        .r_o              (r_o),
        .g_o              (g_o),
        .b_o              (b_o)
    );

endmodule : card_glue_top

`default_nettype wire

//--- verif/tb_clock_gen.sv
// clock source for the card glue testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8   // full clock period
) (
    output logic clk_o
);

    // low at time zero, first rising edge half a period in
    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule : tb_clock_gen

`default_nettype wire

//--- verif/card_glue_assertions.sv
// bound concurrent checks on the card glue top for the mixer handshake, bus direction and reset
`timescale 1ns/1ps
`default_nettype none

module card_glue_assertions
    import card_glue_pkg::*;
(
    input wire                clk_logic_w,
    input wire                device_rst,
    input wire                ssc_rd_i,
    input wire                ssp_rd_i,
    input wire                mb_rd_i,
    input wire                a2_d_dir_o,
    input wire                mix_valid_o,
    input wire                mix_ready_i,
    input wire audio_sample_t mix_l_o
);

    int fail_cnt = 0;   // summed into the testbench error count

    // ==============================
    // mixer output stream
    // ==============================

    // a stalled sample neither drops nor moves
    mix_hold_a : assert property (@(posedge clk_logic_w) disable iff (device_rst)
        mix_valid_o && !mix_ready_i |=> mix_valid_o && $stable(mix_l_o))
    else begin
        fail_cnt++;
        $error("mix_valid_o dropped or mix_l_o changed while the sample waited");
    end

    // nothing left over from before the reset
    mix_reset_a : assert property (@(posedge clk_logic_w) device_rst |-> !mix_valid_o)
    else begin
        fail_cnt++;
        $error("mix_valid_o high while device_rst is asserted");
    end

    // ==============================
    // apple ii bus
    // ==============================

    dir_idle_a : assert property (@(posedge clk_logic_w)
        !(ssc_rd_i || ssp_rd_i || mb_rd_i) |-> !a2_d_dir_o)
    else begin
        fail_cnt++;
        $error("a2_d_dir_o high with no card read enable set");
    end

endmodule : card_glue_assertions

bind card_glue_top card_glue_assertions u_card_glue_assertions (
    .clk_logic_w (clk_logic_w),
    .device_rst  (device_rst),
    .ssc_rd_i    (ssc_rd_i),
    .ssp_rd_i    (ssp_rd_i),
    .mb_rd_i     (mb_rd_i),
    .a2_d_dir_o  (a2_d_dir_o),
    .mix_valid_o (mix_valid_o),
    .mix_ready_i (mix_ready_i),
    .mix_l_o     (mix_l_o)
);

`default_nettype wire

//--- verif/card_glue_tb.sv
// testbench top with stimulus loading, bus, pixel, audio and status tests and the run timeout
`timescale 1ns/1ps
`default_nettype none

module card_glue_tb;
    import card_glue_pkg::*;

    localparam int          MAX_VECS  = 64;
    localparam int          VEC_W     = 112;   // 28 hex digits per stimulus line
    localparam logic [31:0] RAND_SEED = 32'h22b57aee;

    // ==============================
    // dut signals
    // ==============================

    logic          clk_logic_w;
    logic          arst;
    logic          ssc_rd_i, ssp_rd_i, mb_rd_i;
    bus_data_t     ssc_data_i, ssp_data_i, mb_data_i;
    logic          ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i;
    bus_data_t     a2_d_o;
    logic          a2_d_dir_o, a2_irq_n_o;
    logic          speaker_i, audio_valid_i, audio_ready_o;
    logic          mix_valid_o, mix_ready_i;
    audio_src_t    ssp_audio_i, mb_audio_l_i, mb_audio_r_i;
    audio_sample_t mix_l_o, mix_r_o;
    screen_y_t     screen_y_i;
    color_t        r_i, g_i, b_i, r_o, g_o, b_o;
    logic          a2_phi1_i, a2_q3_i;
    logic [1:0]    dip_switches_n_i, led_o, activity_o;

    // ==============================
    // run bookkeeping
    // ==============================

    logic [VEC_W-1:0] vec_mem [MAX_VECS];
    logic [VEC_W-1:0] audio_vecs [$];   // audio lines, sent in file order
    logic [31:0]      exp_q [$];        // {mix_l, mix_r} per accepted input
    int               n_vecs       = 0;
    int               cycle_cnt    = 0;
    int               cycle_limit  = 200;
    int               err_cnt      = 0;
    int               tests_run    = 0;
    int               tests_failed = 0;
    int               test_err_base;

    tb_clock_gen #(
        .PERIOD_NS (8)
    ) u_tb_clock_gen (
        .clk_o (clk_logic_w)
    );

    card_glue_top #(
        .RESET_CYCLES        (4),
        .HEARTBEAT_CYCLES    (10),
        .ACTIVITY_BITS       (4),
        .IRQ_OUT_ENABLE      (1'b1),
        .BUS_DATA_OUT_ENABLE (1'b1),
        .SCANLINES_ENABLE    (1'b0),
        .SPEAKER_ENABLE      (1'b0)
    ) u_card_glue_top (.*);

    // run limit from the number of stimulus lines
    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ==============================
    // helpers
    // ==============================

    function automatic logic [11:0] input_field(input logic [VEC_W-1:0] v, input int idx);
        return v[96 - 12 * idx +: 12];   // in0 sits just below the tag
    endfunction

    function automatic logic [15:0] expect_field(input logic [VEC_W-1:0] v, input int idx);
        return v[32 - 16 * idx +: 16];
    endfunction

    task automatic step_cycle();
        @(posedge clk_logic_w);
        #1;   // inputs change just after the edge
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        $display("Fail %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic flag_problem(input string what);
        err_cnt++;
        $display("Error at %0t ns %s", $time, what);
    endtask

    task automatic open_test();
        test_err_base = err_cnt;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (err_cnt == test_err_base) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, err_cnt - test_err_base);
        end
    endtask

    // ==============================
    // tests
    // ==============================

    // two clocks of arst, then idle values through the stretched reset
    task automatic check_reset_values();
        fork
            begin
                repeat (2) @(posedge clk_logic_w);
                #1 arst = 1'b0;
            end
            repeat (10) begin
                @(negedge clk_logic_w);
                if (mix_valid_o !== 1'b0) report_mismatch("mix_valid_o", mix_valid_o, 0);
                if (led_o !== 2'b01) report_mismatch("led_o", led_o, 2'b01);
                if (a2_d_dir_o !== 1'b0) report_mismatch("a2_d_dir_o", a2_d_dir_o, 0);
                if (a2_irq_n_o !== 1'b1) report_mismatch("a2_irq_n_o", a2_irq_n_o, 1);
            end
        join
        step_cycle();
    endtask

    task automatic drive_bus_vector(input logic [VEC_W-1:0] v);
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'(input_field(v, 0));
        ssc_data_i = bus_data_t'(input_field(v, 1));
        ssp_data_i = bus_data_t'(input_field(v, 2));
        mb_data_i  = bus_data_t'(input_field(v, 3));
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'(input_field(v, 4));
        @(negedge clk_logic_w);   // same cycle, arbiter has no registers
        if (a2_d_o !== bus_data_t'(expect_field(v, 0))) begin
            report_mismatch("a2_d_o", a2_d_o, expect_field(v, 0));
        end
        if (a2_d_dir_o !== 1'(expect_field(v, 1))) begin
            report_mismatch("a2_d_dir_o", a2_d_dir_o, expect_field(v, 1));
        end
        if (a2_irq_n_o !== 1'(expect_field(v, 2))) begin
            report_mismatch("a2_irq_n_o", a2_irq_n_o, expect_field(v, 2));
        end
        step_cycle();
    endtask

    task automatic drive_pixel_vector(input logic [VEC_W-1:0] v);
        dip_switches_n_i[0] = 1'(input_field(v, 0));
        screen_y_i = screen_y_t'(input_field(v, 1));
        r_i        = color_t'(input_field(v, 2));
        g_i        = color_t'(input_field(v, 3));
        b_i        = color_t'(input_field(v, 4));
        @(posedge clk_logic_w);   // the one register stage
        @(negedge clk_logic_w);
        if (r_o !== color_t'(expect_field(v, 0))) report_mismatch("r_o", r_o, expect_field(v, 0));
        if (g_o !== color_t'(expect_field(v, 1))) report_mismatch("g_o", g_o, expect_field(v, 1));
        if (b_o !== color_t'(expect_field(v, 2))) report_mismatch("b_o", b_o, expect_field(v, 2));
        step_cycle();
    endtask

    // sender with random gaps, receiver with random stalls, both at once
    task automatic stream_audio();
        logic        taken;
        logic [31:0] pair;
        int          got;
        got = 0;
        fork
            foreach (audio_vecs[i]) begin
                repeat ($urandom % 3) step_cycle();   // idle gap, valid low
                {dip_switches_n_i[1], speaker_i} = 2'(input_field(audio_vecs[i], 0));
                ssp_audio_i   = audio_src_t'(input_field(audio_vecs[i], 1));
                mb_audio_l_i  = audio_src_t'(input_field(audio_vecs[i], 2));
                mb_audio_r_i  = audio_src_t'(input_field(audio_vecs[i], 3));
                audio_valid_i = 1'b1;
                do begin
                    @(negedge clk_logic_w);
                    taken = audio_ready_o;   // accepted on the coming edge
                    step_cycle();
                end while (!taken);
                exp_q.push_back({expect_field(audio_vecs[i], 0), expect_field(audio_vecs[i], 1)});
                audio_valid_i = 1'b0;
            end
            while (got < audio_vecs.size()) begin
                mix_ready_i = ($urandom % 4) != 0;   // stall about one cycle in four
                @(negedge clk_logic_w);
                // queued expectations are the samples inside the two stages
                if (exp_q.size() < 2 && audio_ready_o !== 1'b1) begin
                    report_mismatch("audio_ready_o", audio_ready_o, 1);
                end
                if (mix_valid_o && mix_ready_i) begin
                    got++;
                    if (exp_q.size() == 0) begin
                        flag_problem("mixer gave a sample with no input accepted for it");
                    end else begin
                        pair = exp_q.pop_front();
                        if (mix_l_o !== pair[31:16]) report_mismatch("mix_l_o", mix_l_o, pair[31:16]);
                        if (mix_r_o !== pair[15:0]) report_mismatch("mix_r_o", mix_r_o, pair[15:0]);
                    end
                end
                step_cycle();
            end
        join
        mix_ready_i = 1'b1;
    endtask

    // slow square wave, three cycles high and three low
    task automatic toggle_bus_clock(input int idx, input int edges);
        repeat (edges) begin
            if (idx == 0) a2_phi1_i = 1'b1;
            else a2_q3_i = 1'b1;
            repeat (3) step_cycle();
            if (idx == 0) a2_phi1_i = 1'b0;
            else a2_q3_i = 1'b0;
            repeat (3) step_cycle();
        end
    endtask

    // 4 bit counter msb, clear after 7 edges and set after 8
    task automatic check_activity(input int idx);
        toggle_bus_clock(idx, 7);
        @(negedge clk_logic_w);
        if (activity_o[idx] !== 1'b0) begin
            report_mismatch($sformatf("activity_o[%0d]", idx), activity_o[idx], 0);
        end
        step_cycle();
        toggle_bus_clock(idx, 1);
        @(negedge clk_logic_w);
        if (activity_o[idx] !== 1'b1) begin
            report_mismatch($sformatf("activity_o[%0d]", idx), activity_o[idx], 1);
        end
        step_cycle();
    endtask

    // first change only syncs up, the next two gaps are measured
    task automatic measure_heartbeat();
        logic prev;
        int   since;
        int   changes;
        since   = 0;
        changes = 0;
        @(negedge clk_logic_w);
        prev = led_o[0];
        while (changes < 3 && since < 30) begin
            @(negedge clk_logic_w);
            since++;
            if (led_o[0] !== prev) begin
                if (changes > 0 && since != 10) report_mismatch("led_o[0] period", since, 10);
                changes++;
                since = 0;
                prev  = led_o[0];
            end
        end
        if (changes < 3) flag_problem("led_o[0] stopped toggling");
        step_cycle();
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin : main_seq
        int seed_ret;
        int assert_fails;
        arst             = 1'b0;
        ssc_rd_i         = 1'b0;
        ssp_rd_i         = 1'b0;
        mb_rd_i          = 1'b0;
        ssc_data_i       = '0;
        ssp_data_i       = '0;
        mb_data_i        = '0;
        ssc_irq_n_i      = 1'b1;
        ssp_irq_n_i      = 1'b1;
        mb_irq_n_i       = 1'b1;
        speaker_i        = 1'b0;
        ssp_audio_i      = '0;
        mb_audio_l_i     = '0;
        mb_audio_r_i     = '0;
        audio_valid_i    = 1'b0;
        mix_ready_i      = 1'b1;
        screen_y_i       = '0;
        r_i              = '0;
        g_i              = '0;
        b_i              = '0;
        a2_phi1_i        = 1'b0;
        a2_q3_i          = 1'b0;
        dip_switches_n_i = 2'b11;   // both switches off
        seed_ret = $urandom(RAND_SEED);

        foreach (vec_mem[i]) begin
            vec_mem[i] = '0;   // tag 0 marks an unused slot
        end
        $readmemh("verif/card_glue_stimulus.txt", vec_mem);
        foreach (vec_mem[i]) begin
            if (vec_mem[i][111:108] != 4'h0) n_vecs++;
            if (vec_mem[i][111:108] == 4'h2) audio_vecs.push_back(vec_mem[i]);
        end
        cycle_limit = n_vecs * 64 + 200;
        #1 arst = 1'b1;   // edge after time zero for the async reset

        open_test();
        if (n_vecs == 0) flag_problem("no vectors read from the stimulus file");
        check_reset_values();
        close_test("reset values");

        open_test();
        foreach (vec_mem[i]) begin
            if (vec_mem[i][111:108] == 4'h1) drive_bus_vector(vec_mem[i]);
        end
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b000;   // bus back to idle
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        close_test("bus arbitration");

        open_test();
        foreach (vec_mem[i]) begin
            if (vec_mem[i][111:108] == 4'h3) drive_pixel_vector(vec_mem[i]);
        end
        close_test("scanline pixels");

        open_test();
        stream_audio();
        close_test("audio mix");

        open_test();
        check_activity(0);
        @(negedge clk_logic_w);
        if (activity_o[1] !== 1'b0) report_mismatch("activity_o[1]", activity_o[1], 0);
        if (led_o[1] !== 1'b1) report_mismatch("led_o[1]", led_o[1], 1);
        step_cycle();
        check_activity(1);
        close_test("bus clock activity");

        open_test();
        measure_heartbeat();
        close_test("heartbeat");

        assert_fails = u_card_glue_top.u_card_glue_assertions.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : card_glue_tb

`default_nettype wire

//--- verif/card_glue_stimulus.txt
// tag then in0..in4 then exp0..exp2  bus 1 rd ssc_d ssp_d mb_d irq_n, expect d dir irq_n
// audio 2 {sw_spk_n,spk} ssp mb_l mb_r, expect l r  pixel 3 sw_scan_n y r g b, expect r g b
1_000_05c_03a_0e1_007_0000_0000_0001
1_001_05c_03a_0e1_006_00e1_0001_0000
1_002_05c_03a_0e1_005_003a_0001_0000
1_003_05c_03a_0e1_003_003a_0001_0000
1_004_05c_03a_0e1_007_005c_0001_0001
1_005_0a7_03a_0e1_000_00a7_0001_0000
1_006_05c_0ff_0e1_007_005c_0001_0001
1_007_011_022_033_001_0011_0001_0000
2_002_000_000_000_000_0000_0000_0000
2_003_100_080_3ff_000_0c00_27f8_0000
2_002_3ff_3ff_001_000_3ff0_2000_0000
2_001_3ff_3ff_3ff_000_4ff0_4ff0_0000
2_000_055_0aa_123_000_07f8_0bc0_0000
2_001_001_002_200_000_1018_2008_0000
3_001_001_0ff_080_003_00ff_0080_0003
3_000_001_0ff_080_003_007f_0040_0001
3_000_002_081_042_0fe_0081_0042_00fe
3_000_3ff_081_042_0fe_0040_0021_007f

//--- vlog.f
rtl/card_glue_pkg.sv
rtl/por_reset_gen.sv
rtl/status_leds.sv
rtl/bus_data_arbiter.sv
rtl/audio_mixer.sv
rtl/scanline_dimmer.sv
rtl/card_glue_top.sv
verif/tb_clock_gen.sv
verif/card_glue_assertions.sv
verif/card_glue_tb.sv
